/* hw/stream_regex_settings.svh */
`ifndef STREAM_REGEX_SETTINGS_SVH
`define STREAM_REGEX_SETTINGS_SVH

// Width of one incoming character
`define SR_CHAR_W 8

// Stream id width and the number of streams it can address
`define SR_STREAM_W 6
`define SR_STREAMS 64

// Matched-packet counter width, wraps on overflow
`define SR_COUNT_W 16

// Bits needed to hold one saved matcher state
`define SR_STATE_W 3

`endif

/* hw/stream_regex_pkg.sv */
`include "stream_regex_settings.svh"

package stream_regex_pkg;

   // Character classes after case folding
   // One code per distinct keyword letter, everything else is CLS_OTHER
   typedef enum logic [2:0]
   {
      CLS_J,
      CLS_A,
      CLS_B,
      CLS_E,
      CLS_R,
      CLS_OTHER
   } char_class_e;

   // Matcher states, named after the prefix of "jabber" seen so far
   // ST_MATCH is entered on the final r and acts like ST_IDLE afterwards
   typedef enum logic [`SR_STATE_W-1:0]
   {
      ST_IDLE,
      ST_J,
      ST_JA,
      ST_JAB,
      ST_JABB,
      ST_JABBE,
      ST_MATCH
   } dfa_state_e;

endpackage

/* hw/stream_decoder.sv */
`timescale 1ns/10ps
`include "stream_regex_settings.svh"

module stream_decoder (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          pkt_start,
   input  logic [`SR_STREAM_W-1:0]       stream_id,
   input  logic [`SR_CHAR_W-1:0]         char_in,
   input  logic                          char_in_vld,
   input  logic                          pkt_end,
   input  logic                          enable,
   output logic                          load_state,
   output logic                          new_stream_id,
   output logic [`SR_STREAM_W-1:0]       cur_stream,
   output stream_regex_pkg::char_class_e cls,
   output logic                          cls_vld,
   output logic                          eop,
   output logic                          commit
);

   // Bit that turns an ASCII capital into its lower case form
   localparam logic [`SR_CHAR_W-1:0] CASE_BIT = 'h20;

   // One bit per stream, set once the stream has saved state
   logic [`SR_STREAMS-1:0] known_q;

   // First stage of the end-of-packet delay line
   logic end_d1;
   logic cmt_d1;

   // Folded character and its class, ahead of the register
   logic [`SR_CHAR_W-1:0]         folded;
   stream_regex_pkg::char_class_e char_class;

   // Case folding, only letters A..Z are touched
   always_comb
   begin
      folded = char_in;
      if (char_in >= "A" && char_in <= "Z")
         folded = char_in | CASE_BIT;
   end

   // Map the folded character onto the keyword alphabet
   always_comb
   begin
      case (folded)
         "j":     char_class = stream_regex_pkg::CLS_J;
         "a":     char_class = stream_regex_pkg::CLS_A;
         "b":     char_class = stream_regex_pkg::CLS_B;
         "e":     char_class = stream_regex_pkg::CLS_E;
         "r":     char_class = stream_regex_pkg::CLS_R;
         default: char_class = stream_regex_pkg::CLS_OTHER;
      endcase
   end

   // Strobes, delay line and the known-stream bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         load_state <= 1'b0;
         cls_vld    <= 1'b0;
         end_d1     <= 1'b0;
         cmt_d1     <= 1'b0;
         eop        <= 1'b0;
         commit     <= 1'b0;
         known_q    <= '0;
      end
      else
      begin
         // Restore request goes out one cycle after pkt_start
         load_state <= pkt_start;
         cls_vld    <= char_in_vld;
         // Two stages so the last accept reaches the flag before eop
         // enable is sampled here and nowhere else
         end_d1     <= pkt_end;
         cmt_d1     <= pkt_end & enable;
         eop        <= end_d1;
         commit     <= cmt_d1;
         // A committed stream now has saved state in the tally
         if (commit)
            known_q[cur_stream] <= 1'b1;
      end
   end

   // Packet framing and character payload
   always_ff @(posedge clk)
   begin
      if (pkt_start)
      begin
         cur_stream    <= stream_id;
         new_stream_id <= ~known_q[stream_id];
      end
      if (char_in_vld)
         cls <= char_class;
   end

endmodule

/* hw/keyword_dfa.sv */
`timescale 1ns/10ps
`include "stream_regex_settings.svh"

module keyword_dfa (
   input  logic                          clk,
   input  logic                          rst_n,
   input  stream_regex_pkg::char_class_e cls,
   input  logic                          cls_vld,
   input  logic [`SR_STATE_W-1:0]        state_in,
   input  logic                          state_in_vld,
   output logic [`SR_STATE_W-1:0]        state_out,
   output logic                          accept_out
);

   // Current matcher state and the state after the pending class
   stream_regex_pkg::dfa_state_e state_q;
   stream_regex_pkg::dfa_state_e state_nxt;

   // One step along j-a-b-b-e-r
   function automatic stream_regex_pkg::dfa_state_e advance(
      input stream_regex_pkg::dfa_state_e cur,
      input stream_regex_pkg::char_class_e c
   );
      stream_regex_pkg::dfa_state_e restart;
      stream_regex_pkg::dfa_state_e nxt;
      // On a mismatch a j can still begin a fresh keyword
      restart = (c == stream_regex_pkg::CLS_J) ? stream_regex_pkg::ST_J
                                               : stream_regex_pkg::ST_IDLE;
      nxt = restart;
      case (cur)
         stream_regex_pkg::ST_J:
            if (c == stream_regex_pkg::CLS_A)
               nxt = stream_regex_pkg::ST_JA;
         stream_regex_pkg::ST_JA:
            if (c == stream_regex_pkg::CLS_B)
               nxt = stream_regex_pkg::ST_JAB;
         stream_regex_pkg::ST_JAB:
            if (c == stream_regex_pkg::CLS_B)
               nxt = stream_regex_pkg::ST_JABB;
         stream_regex_pkg::ST_JABB:
            if (c == stream_regex_pkg::CLS_E)
               nxt = stream_regex_pkg::ST_JABBE;
         stream_regex_pkg::ST_JABBE:
            if (c == stream_regex_pkg::CLS_R)
               nxt = stream_regex_pkg::ST_MATCH;
         // ST_IDLE, ST_MATCH and unused codes only leave on a j
         default:
            nxt = restart;
      endcase
      return nxt;
   endfunction

   always_comb
   begin
      state_nxt = advance(state_q, cls);
   end

   // State register with load, plus the accept pulse
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q    <= stream_regex_pkg::ST_IDLE;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         if (state_in_vld)
            // Restored state wins, it arrives before the first character
            state_q <= stream_regex_pkg::dfa_state_e'(state_in);
         else if (cls_vld)
         begin
            state_q    <= state_nxt;
            // Pulse only on entry into ST_MATCH
            accept_out <= (state_nxt == stream_regex_pkg::ST_MATCH);
         end
      end
   end

   // Raw bits go back to the tally for saving
   assign state_out = state_q;

endmodule

/* hw/stream_tally.sv */
`timescale 1ns/10ps
`include "stream_regex_settings.svh"

module stream_tally (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   load_state,
   input  logic                   new_stream_id,
   input  logic [`SR_STREAM_W-1:0] cur_stream,
   input  logic                   eop,
   input  logic                   commit,
   input  logic [`SR_STATE_W-1:0] state_out,
   input  logic                   accept_out,
   output logic [`SR_STATE_W-1:0] state_in,
   output logic                   state_in_vld,
   output logic [`SR_COUNT_W-1:0] count,
   output logic                   fired
);

   // Saved matcher state, one entry per stream
   logic [`SR_STATE_W-1:0] state_mem [`SR_STREAMS];

   // Speculative match flag for the packet in flight
   logic match_q;

   // Flag widened to the counter width for the add
   logic [`SR_COUNT_W-1:0] match_inc;

   assign match_inc = {{(`SR_COUNT_W-1){1'b0}}, match_q};

   // The flag itself is the fired level
   assign fired = match_q;

   // Control side: restore strobe, flag and counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_in_vld <= 1'b0;
         match_q      <= 1'b0;
         count        <= '0;
      end
      else
      begin
         // One-cycle load pulse toward the matcher
         state_in_vld <= load_state;

         // New packet, nothing matched yet
         if (load_state)
            match_q <= 1'b0;

         // Any keyword completion in this packet sets the flag
         if (accept_out)
            match_q <= 1'b1;

         // Enabled packet, count it once if it matched
         if (commit)
            count <= count + match_inc;

         // Disabled packet, drop the speculative result
         if (eop && !commit)
            match_q <= 1'b0;
      end
   end

   // Data side: state restore and save
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         // Unknown stream starts from idle, known stream resumes
         if (new_stream_id)
            state_in <= stream_regex_pkg::ST_IDLE;
         else
            state_in <= state_mem[cur_stream];
      end

      // Save only for enabled packets
      // disabled ones leave the previous state in place
      if (commit)
         state_mem[cur_stream] <= state_out;
   end

endmodule

/* hw/stream_regex_top.sv */
`timescale 1ns/10ps
`include "stream_regex_settings.svh"

module stream_regex_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    pkt_start,
   input  logic [`SR_STREAM_W-1:0] stream_id,
   input  logic [`SR_CHAR_W-1:0]   char_in,
   input  logic                    char_in_vld,
   input  logic                    pkt_end,
   input  logic                    enable,
   output logic [`SR_COUNT_W-1:0]  count,
   output logic                    fired
);

   // Decoder to tally
   logic                    load_state;
   logic                    new_stream_id;
   logic [`SR_STREAM_W-1:0] cur_stream;
   logic                    eop;
   logic                    commit;

   // Decoder to matcher
   stream_regex_pkg::char_class_e cls;
   logic                          cls_vld;

   // Tally and matcher, both directions
   logic [`SR_STATE_W-1:0] state_in;
   logic                   state_in_vld;
   logic [`SR_STATE_W-1:0] state_out;
   logic                   accept_out;

   // Framing, case folding and end-of-packet alignment
   stream_decoder i_stream_decoder (
      .clk           (clk),
      .rst_n         (rst_n),
      .pkt_start     (pkt_start),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .pkt_end       (pkt_end),
      .enable        (enable),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .cur_stream    (cur_stream),
      .cls           (cls),
      .cls_vld       (cls_vld),
      .eop           (eop),
      .commit        (commit)
   );

   // Keyword matcher
   keyword_dfa i_keyword_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .cls          (cls),
      .cls_vld      (cls_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Per-stream state memory and the packet count
   stream_tally i_stream_tally (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .cur_stream    (cur_stream),
      .eop           (eop),
      .commit        (commit),
      .state_out     (state_out),
      .accept_out    (accept_out),
      .state_in      (state_in),
      .state_in_vld  (state_in_vld),
      .count         (count),
      .fired         (fired)
   );

endmodule

/* verification/stream_regex_tb.sv */
`timescale 1ns/10ps
`include "stream_regex_settings.svh"

module stream_regex_tb;

   localparam int NUM_ROWS     = 15;
   localparam int MAX_CHARS    = 12;
   localparam int RESET_CYCLES = 8;
   // Worst row is start, gap, characters, end, checks, 4 spacing and 3 idle
   localparam int ROW_CYCLES     = MAX_CHARS + 10;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_CYCLES + 20;

   // DUT ports
   logic                    clk;
   logic                    rst_n;
   logic                    pkt_start;
   logic [`SR_STREAM_W-1:0] stream_id;
   logic [`SR_CHAR_W-1:0]   char_in;
   logic                    char_in_vld;
   logic                    pkt_end;
   logic                    enable;
   logic [`SR_COUNT_W-1:0]  count;
   logic                    fired;

   // Packet table, one entry per row
   logic [`SR_STREAM_W-1:0] row_stream [NUM_ROWS];
   string                   row_text   [NUM_ROWS];
   int                      row_len    [NUM_ROWS];
   logic                    row_enable [NUM_ROWS];
   logic                    row_fired  [NUM_ROWS];
   logic [`SR_COUNT_W-1:0]  row_count  [NUM_ROWS];
   int                      num_filled = 0;

   // Idle-gap generator state
   logic [31:0] lfsr_q = 32'hd930;

   int error_count = 0;
   int check_count = 0;
   int cycle_count = 0;

   stream_regex_top i_stream_regex_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .pkt_start   (pkt_start),
      .stream_id   (stream_id),
      .char_in     (char_in),
      .char_in_vld (char_in_vld),
      .pkt_end     (pkt_end),
      .enable      (enable),
      .count       (count),
      .fired       (fired)
   );

   // 10 ns clock
   initial
   begin
      clk = 1'b0;
   end

   always #5 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the packet sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // Append one packet with its expected results
   task automatic add_row(
      input logic [`SR_STREAM_W-1:0] id,
      input string                   text,
      input logic                    en,
      input logic                    exp_fired,
      input logic [`SR_COUNT_W-1:0]  exp_count
   );
      row_stream[num_filled] = id;
      row_text[num_filled]   = text;
      row_len[num_filled]    = text.len();
      row_enable[num_filled] = en;
      row_fired[num_filled]  = exp_fired;
      row_count[num_filled]  = exp_count;
      num_filled++;
   endtask

   // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
   function automatic int random_bits(input int nbits);
      logic fb;
      int   value;
      value = 0;
      for (int i = 0; i < nbits; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         value  = (value << 1) | int'(fb);
      end
      return value;
   endfunction

   // Drive one packet and check fired, then count
   task automatic run_row(input int r);
      int    idle;
      string text;
      logic  exp_late;
      text = row_text[r];
      idle = random_bits(2);
      repeat (idle) @(posedge clk);
      @(posedge clk);
      pkt_start <= 1'b1;
      stream_id <= row_stream[r];
      @(posedge clk);
      pkt_start <= 1'b0;
      // Characters begin 2 cycles after pkt_start
      for (int i = 0; i < row_len[r]; i++)
      begin
         @(posedge clk);
         char_in     <= text.getc(i);
         char_in_vld <= 1'b1;
      end
      @(posedge clk);
      char_in_vld <= 1'b0;
      @(posedge clk);
      pkt_end <= 1'b1;
      enable  <= row_enable[r];
      @(posedge clk);
      pkt_end <= 1'b0;
      enable  <= 1'b0;
      @(posedge clk);
      // Flag holds the packet's result two cycles after pkt_end
      @(negedge clk);
      check_count++;
      if (fired !== row_fired[r])
      begin
         $display("error fired: row %0d got %h expected %h", r, fired, row_fired[r]);
         error_count++;
      end
      @(posedge clk);
      // Count has moved and a disabled flag is gone three cycles after pkt_end
      @(negedge clk);
      check_count++;
      if (count !== row_count[r])
      begin
         $display("error count: row %0d got %h expected %h", r, count, row_count[r]);
         error_count++;
      end
      exp_late = row_enable[r] ? row_fired[r] : 1'b0;
      check_count++;
      if (fired !== exp_late)
      begin
         $display("error fired: row %0d after eop got %h expected %h", r, fired, exp_late);
         error_count++;
      end
   endtask

   initial
   begin
      rst_n       = 1'b0;
      pkt_start   = 1'b0;
      stream_id   = '0;
      char_in     = '0;
      char_in_vld = 1'b0;
      pkt_end     = 1'b0;
      enable      = 1'b0;

      // Mixed-case single match and a double keyword counted once
      add_row(6'd1, "JaBbEr", 1'b1, 1'b1, 16'd1);
      add_row(6'd2, "jabberjabber", 1'b1, 1'b1, 16'd2);
      // Keyword split over two packets of stream 3
      add_row(6'd3, "jab", 1'b1, 1'b0, 16'd2);
      add_row(6'd3, "ber", 1'b1, 1'b1, 16'd3);
      // Stream 9 is new and starts idle while stream 5 keeps its prefix
      add_row(6'd5, "jab", 1'b1, 1'b0, 16'd3);
      add_row(6'd9, "ber", 1'b1, 1'b0, 16'd3);
      add_row(6'd5, "ber", 1'b1, 1'b1, 16'd4);
      // Disabled match is not counted and not saved
      add_row(6'd7, "jab", 1'b1, 1'b0, 16'd4);
      add_row(6'd7, "jabber", 1'b0, 1'b1, 16'd4);
      add_row(6'd7, "ber", 1'b1, 1'b1, 16'd5);
      // Disabled first packet leaves stream 11 unknown
      add_row(6'd11, "jab", 1'b0, 1'b0, 16'd5);
      add_row(6'd11, "ber", 1'b1, 1'b0, 16'd5);
      // Mismatching j restarts and an extra b drops back to idle
      add_row(6'd12, "jabbjabber", 1'b1, 1'b1, 16'd6);
      add_row(6'd13, "jabbber", 1'b1, 1'b0, 16'd6);
      // Saved match state resumes as idle so a keyword tail alone does not fire
      add_row(6'd1, "abber", 1'b1, 1'b0, 16'd6);

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      // Idle values straight out of reset
      check_count++;
      if (count !== '0)
      begin
         $display("error count: after reset got %h expected %h", count, 16'h0);
         error_count++;
      end
      check_count++;
      if (fired !== 1'b0)
      begin
         $display("error fired: after reset got %h expected %h", fired, 1'b0);
         error_count++;
      end

      for (int r = 0; r < num_filled; r++)
         run_row(r);

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* stream_regex.f */
+incdir+hw
hw/stream_regex_pkg.sv
hw/stream_decoder.sv
hw/keyword_dfa.sv
hw/stream_tally.sv
hw/stream_regex_top.sv
verification/stream_regex_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module stream_regex_tb \
   -f stream_regex.f -o stream_regex_sim > build.log 2>&1 &&
./obj_dir/stream_regex_sim > sim.log 2>&1 &&
grep -qx "TESTS PASSED" sim.log &&
echo "simulation ok, see sim.log" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
exit 0
